// File: design/exe_pkg.sv
package exe_pkg;

   // ---------------------------------------------------------
   // Widths
   // ---------------------------------------------------------
   localparam int xlen     = 32;                  // Data and address width
   localparam int num_gprs = 32;                  // x0..x31

   typedef logic [xlen-1:0]             word_t;   // Register data word
   typedef logic [xlen-1:0]             pc_t;     // Instruction address
   typedef logic [$clog2(num_gprs)-1:0] reg_addr_t;
   typedef logic [2:0]                  funct3_t; // Instruction funct3 field
   typedef logic [2:0]                  ls_size_t; // Bytes per access, 1/2/4

   // ---------------------------------------------------------
   // Instruction classes and operations
   // ---------------------------------------------------------
   typedef enum logic [2:0] {
      alu_instr,
      br_instr,
      ld_instr,
      st_instr,
      ill_instr                                   // Nothing executes, passed on for trap
   } instr_group_t;

   // Bare names would collide with SV operator keywords
   typedef enum logic [3:0] {
      alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
      alu_xor, alu_srl, alu_sra, alu_or,  alu_and
   } alu_op_t;

   typedef enum logic [1:0] {b_cond, b_jal, b_jalr} br_op_t;

   typedef enum logic [1:0] {sel_rs, sel_pc, sel_imm} opnd_sel_t;

   // ---------------------------------------------------------
   // Records between stages
   // ---------------------------------------------------------
   typedef struct packed {
      pc_t          pc;
      word_t        imm;                          // Sign extended by decode
      funct3_t      funct3;
      instr_group_t ig;
      logic [3:0]   op;                           // Cast per unit to its own op enum
      opnd_sel_t    sel_x;
      opnd_sel_t    sel_y;
      reg_addr_t    rd_addr;
      reg_addr_t    rs1_addr;
      reg_addr_t    rs2_addr;
      logic         rd_wr;
      logic         rs1_rd;                       // Rs1 actually used
      logic         rs2_rd;
      pc_t          predicted_addr;               // Where fetch went next
   } dec_to_exe_t;

   typedef struct packed {
      logic      valid;
      logic      rd_wr;
      reg_addr_t rd_addr;
      word_t     rd_data;
   } fwd_gpr_t;

   typedef struct packed {
      pc_t          pc;
      instr_group_t ig;
      logic         rd_wr;
      reg_addr_t    rd_addr;
      word_t        rd_data;
      logic         mispre;                       // Fetch was redirected
      logic         mis;                          // Misaligned target or access
      pc_t          br_pc;
      logic         is_ld;
      logic         is_st;
      word_t        ls_addr;
      word_t        st_data;
      ls_size_t     size;
      logic         zero_ext;                     // LBU/LHU
      logic         inv_flag;                     // Store hits I-cache window
   } exe_to_mem_t;

endpackage

// File: design/operand_forward.sv
module operand_forward
(
   input  exe_pkg::reg_addr_t                     rs1_addr,
   input  exe_pkg::reg_addr_t                     rs2_addr,
   input  logic                                   rs1_rd,
   input  logic                                   rs2_rd,
   input  exe_pkg::word_t [exe_pkg::num_gprs-1:0] gpr,
   input  exe_pkg::fwd_gpr_t                      fwd_mem,
   input  exe_pkg::fwd_gpr_t                      fwd_wb,
   output exe_pkg::word_t                         rs1_data,
   output exe_pkg::word_t                         rs2_data
);

   // One source operand. Youngest producer wins, MEM before WB before file
   function automatic exe_pkg::word_t fwd_pick
   (
      input exe_pkg::reg_addr_t addr,
      input logic               rd,
      input exe_pkg::word_t     file_data,
      input exe_pkg::fwd_gpr_t  mem,
      input exe_pkg::fwd_gpr_t  wb
   );
      logic hit_mem;
      logic hit_wb;
      hit_mem = rd & mem.valid & mem.rd_wr & (addr == mem.rd_addr) & (addr != '0);
      hit_wb  = rd & wb.valid & wb.rd_wr & (addr == wb.rd_addr) & (addr != '0);
      if (hit_mem)
         return mem.rd_data;
      else if (hit_wb)
         return wb.rd_data;
      return file_data;                            // x0 always comes from here
   endfunction

   assign rs1_data = fwd_pick(rs1_addr, rs1_rd, gpr[rs1_addr], fwd_mem, fwd_wb);
   assign rs2_data = fwd_pick(rs2_addr, rs2_rd, gpr[rs2_addr], fwd_mem, fwd_wb);

endmodule

// File: design/alu_unit.sv
module alu_unit
(
   input  exe_pkg::dec_to_exe_t instr,
   input  exe_pkg::word_t       rs1_data,
   input  exe_pkg::word_t       rs2_data,
   output exe_pkg::word_t       result
);

   exe_pkg::word_t                   x;
   exe_pkg::word_t                   y;
   exe_pkg::alu_op_t                 op;
   logic [$clog2(exe_pkg::xlen)-1:0] shamt;

   assign op    = exe_pkg::alu_op_t'(instr.op);
   assign shamt = y[$clog2(exe_pkg::xlen)-1:0];    // RV32I uses low 5 bits only

   // Operand muxes
   always_comb
   begin
      case (instr.sel_x)
         exe_pkg::sel_pc:  x = instr.pc;           // AUIPC
         exe_pkg::sel_imm: x = '0;                 // LUI: 0 + imm
         default:          x = rs1_data;
      endcase
      y = (instr.sel_y == exe_pkg::sel_imm) ? instr.imm : rs2_data;
   end

   always_comb
   begin
      case (op)
         exe_pkg::alu_add:  result = x + y;
         exe_pkg::alu_sub:  result = x - y;
         exe_pkg::alu_sll:  result = x << shamt;
         exe_pkg::alu_slt:  result = exe_pkg::word_t'($signed(x) < $signed(y));
         exe_pkg::alu_sltu: result = exe_pkg::word_t'(x < y);
         exe_pkg::alu_xor:  result = x ^ y;
         exe_pkg::alu_srl:  result = x >> shamt;
         exe_pkg::alu_sra:  result = exe_pkg::word_t'($signed(x) >>> shamt);
         exe_pkg::alu_or:   result = x | y;
         exe_pkg::alu_and:  result = x & y;
         default:           result = '0;           // Unused op codes
      endcase
   end

endmodule

// File: design/branch_unit.sv
module branch_unit
(
   input  exe_pkg::dec_to_exe_t instr,
   input  exe_pkg::word_t       rs1_data,
   input  exe_pkg::word_t       rs2_data,
   output exe_pkg::pc_t         br_pc,
   output exe_pkg::pc_t         link_pc,
   output logic                 mis
);

   exe_pkg::br_op_t op;
   exe_pkg::pc_t    seq_pc;                       // Fall-through address
   exe_pkg::word_t  jalr_sum;
   logic            taken;

   assign op       = exe_pkg::br_op_t'(instr.op[1:0]);
   assign seq_pc   = instr.pc + exe_pkg::pc_t'(4);
   assign jalr_sum = rs1_data + instr.imm;

   // Bxx condition from funct3
   always_comb
   begin
      case (instr.funct3)
         3'b000:  taken = (rs1_data == rs2_data);                    // BEQ
         3'b001:  taken = (rs1_data != rs2_data);                    // BNE
         3'b100:  taken = ($signed(rs1_data) <  $signed(rs2_data));  // BLT
         3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data));  // BGE
         3'b110:  taken = (rs1_data <  rs2_data);                    // BLTU
         3'b111:  taken = (rs1_data >= rs2_data);                    // BGEU
         default: taken = 1'b0;
      endcase
   end

   always_comb
   begin
      case (op)
         exe_pkg::b_cond: br_pc = taken ? (instr.pc + instr.imm) : seq_pc;
         exe_pkg::b_jal:  br_pc = instr.pc + instr.imm;
         exe_pkg::b_jalr: br_pc = {jalr_sum[exe_pkg::xlen-1:1], 1'b0}; // LSB dropped per spec
         default:         br_pc = seq_pc;
      endcase
   end

   assign link_pc = seq_pc;                       // Rd value for JAL/JALR
   assign mis     = br_pc[1];                     // No C extension, so 4-byte alignment

endmodule

// File: design/ls_unit.sv
module ls_unit
#(
   parameter exe_pkg::word_t icache_lo = 32'h0000_0000,
   parameter exe_pkg::word_t icache_hi = 32'h0000_7FFF
)
(
   input  exe_pkg::dec_to_exe_t instr,
   input  exe_pkg::word_t       rs1_data,
   input  exe_pkg::word_t       rs2_data,
   output exe_pkg::word_t       ls_addr,
   output exe_pkg::word_t       st_data,
   output exe_pkg::ls_size_t    size,
   output logic                 zero_ext,
   output logic                 mis,
   output logic                 inv_flag
);

   assign ls_addr = rs1_data + instr.imm;         // Effective address

   // funct3[1:0] gives width, unused upper lanes of store data are cleared
   always_comb
   begin
      case (instr.funct3[1:0])
         2'b00:
         begin
            size    = 3'd1;
            st_data = exe_pkg::word_t'(rs2_data[7:0]);
            mis     = 1'b0;                       // Bytes never misalign
         end
         2'b01:
         begin
            size    = 3'd2;
            st_data = exe_pkg::word_t'(rs2_data[15:0]);
            mis     = ls_addr[0];
         end
         default:
         begin
            size    = 3'd4;
            st_data = rs2_data;
            mis     = |ls_addr[1:0];
         end
      endcase
   end

   assign zero_ext = instr.funct3[2];             // LBU/LHU
   assign inv_flag = (ls_addr >= icache_lo) && (ls_addr <= icache_hi); // Self-modifying code
endmodule

// File: design/exe_result_select.sv
module exe_result_select
(
   input  logic                 in_valid,
   input  exe_pkg::dec_to_exe_t instr,
   input  exe_pkg::word_t       alu_result,
   input  exe_pkg::pc_t         br_pc,
   input  exe_pkg::pc_t         link_pc,
   input  logic                 br_mis,
   input  exe_pkg::word_t       ls_addr,
   input  exe_pkg::word_t       st_data,
   input  exe_pkg::ls_size_t    size,
   input  logic                 zero_ext,
   input  logic                 ls_mis,
   input  logic                 inv_flag,
   output exe_pkg::exe_to_mem_t exe_out,
   output logic                 rld_pc_flag,
   output exe_pkg::pc_t         rld_pc_addr
);

   exe_pkg::br_op_t br_op;
   logic            rd_wr_ok;                     // Rd write with x0 filtered
   logic            mispre;

   assign br_op    = exe_pkg::br_op_t'(instr.op[1:0]);
   assign rd_wr_ok = instr.rd_wr & (instr.rd_addr != '0);
   assign mispre   = (instr.predicted_addr != br_pc);

   always_comb
   begin
      exe_out     = '0;                           // Fields not set below stay zero
      rld_pc_flag = 1'b0;
      rld_pc_addr = '0;
      if (in_valid)
      begin
         exe_out.pc = instr.pc;
         exe_out.ig = instr.ig;
         case (instr.ig)
            exe_pkg::alu_instr:
            begin
               exe_out.rd_wr   = rd_wr_ok;
               exe_out.rd_addr = instr.rd_addr;
               exe_out.rd_data = alu_result;
            end
            exe_pkg::br_instr:
            begin
               exe_out.br_pc = br_pc;
               if (br_mis)
                  exe_out.mis = 1'b1;             // Trap taken in MEM, no redirect here
               else if (mispre)
               begin
                  exe_out.mispre = 1'b1;
                  rld_pc_flag    = 1'b1;          // Fetch restarts at real target
                  rld_pc_addr    = br_pc;
               end
               else if (br_op != exe_pkg::b_cond)
               begin
                  exe_out.rd_wr   = rd_wr_ok;     // Link write only once path is confirmed
                  exe_out.rd_addr = instr.rd_addr;
                  exe_out.rd_data = link_pc;
               end
            end
            exe_pkg::ld_instr:
            begin
               exe_out.is_ld    = 1'b1;
               exe_out.rd_wr    = rd_wr_ok;       // Data itself arrives in MEM
               exe_out.rd_addr  = instr.rd_addr;
               exe_out.ls_addr  = ls_addr;
               exe_out.size     = size;
               exe_out.zero_ext = zero_ext;
               exe_out.mis      = ls_mis;
            end
            exe_pkg::st_instr:
            begin
               exe_out.is_st    = 1'b1;
               exe_out.ls_addr  = ls_addr;
               exe_out.st_data  = st_data;
               exe_out.size     = size;
               exe_out.inv_flag = inv_flag;
               exe_out.mis      = ls_mis;
            end
            default: ;                            // Illegal, pc and ig only
         endcase
      end
   end

endmodule

// File: design/exe_pipe_reg.sv
module exe_pipe_reg
(
   input  logic                 clk_in,
   input  logic                 reset,
   input  logic                 flush,
   input  logic                 write,
   input  logic                 read,
   input  exe_pkg::exe_to_mem_t data_in,
   output logic                 full,
   output exe_pkg::exe_to_mem_t data_out
);

   // Full flag, write wins over read in the same cycle
   always_ff @(posedge clk_in)
   begin
      if (reset | flush)
         full <= 1'b0;
      else if (write)
         full <= 1'b1;
      else if (read)
         full <= 1'b0;
   end

   always_ff @(posedge clk_in)
   begin
      if (write)
         data_out <= data_in;                     // Holds while stalled
   end

endmodule

// File: design/execute_stage.sv
module execute_stage
(
   input  logic                                   clk_in,
   input  logic                                   reset,
   input  logic                                   cpu_halt,
   input  logic                                   pipe_flush,
   input  logic                                   in_valid,
   output logic                                   in_ready,
   input  exe_pkg::dec_to_exe_t                   in_data,
   input  exe_pkg::word_t [exe_pkg::num_gprs-1:0] gpr,
   input  exe_pkg::fwd_gpr_t                      fwd_mem,
   input  exe_pkg::fwd_gpr_t                      fwd_wb,
   output logic                                   out_valid,
   input  logic                                   out_ready,
   output exe_pkg::exe_to_mem_t                   out_data,
   output logic                                   rld_pc_flag,
   output exe_pkg::pc_t                           rld_pc_addr
);

   logic                 xfer_in;                 // Decode -> EXE handshake
   logic                 xfer_out;                // EXE -> MEM handshake
   logic                 pipe_full;
   exe_pkg::word_t       rs1_data;
   exe_pkg::word_t       rs2_data;
   exe_pkg::word_t       alu_result;
   exe_pkg::pc_t         br_pc;
   exe_pkg::pc_t         link_pc;
   logic                 br_mis;
   exe_pkg::word_t       ls_addr;
   exe_pkg::word_t       st_data;
   exe_pkg::ls_size_t    size;
   logic                 zero_ext;
   logic                 ls_mis;
   logic                 inv_flag;
   exe_pkg::exe_to_mem_t exe_dout;                // Record before the pipe register

   // ---------------------------------------------------------
   // Handshake
   // ---------------------------------------------------------
   assign in_ready  = !reset & !cpu_halt & !pipe_flush & (!pipe_full | xfer_out);
   assign xfer_in   = in_valid & in_ready;
   assign xfer_out  = pipe_full & out_ready;
   assign out_valid = pipe_full;

   operand_forward u_fwd (.rs1_addr(in_data.rs1_addr), .rs2_addr(in_data.rs2_addr),
                          .rs1_rd(in_data.rs1_rd), .rs2_rd(in_data.rs2_rd), .gpr(gpr),
                          .fwd_mem(fwd_mem), .fwd_wb(fwd_wb),
                          .rs1_data(rs1_data), .rs2_data(rs2_data));

   // ---------------------------------------------------------
   // Functional units, all single cycle
   // ---------------------------------------------------------
   alu_unit u_alu (.instr(in_data), .rs1_data(rs1_data), .rs2_data(rs2_data),
                   .result(alu_result));

   branch_unit u_br (.instr(in_data), .rs1_data(rs1_data), .rs2_data(rs2_data),
                     .br_pc(br_pc), .link_pc(link_pc), .mis(br_mis));

   ls_unit #(.icache_lo(32'h0000_0000), .icache_hi(32'h0000_7FFF)) u_ls  // L1 I$ range
   (
      .instr(in_data), .rs1_data(rs1_data), .rs2_data(rs2_data), .ls_addr(ls_addr),
      .st_data(st_data), .size(size), .zero_ext(zero_ext), .mis(ls_mis), .inv_flag(inv_flag)
   );

   exe_result_select u_sel
   (
      .in_valid(in_valid), .instr(in_data), .alu_result(alu_result), .br_pc(br_pc),
      .link_pc(link_pc), .br_mis(br_mis), .ls_addr(ls_addr), .st_data(st_data),
      .size(size), .zero_ext(zero_ext), .ls_mis(ls_mis), .inv_flag(inv_flag),
      .exe_out(exe_dout), .rld_pc_flag(rld_pc_flag), .rld_pc_addr(rld_pc_addr)
   );

   exe_pipe_reg u_pipe (.clk_in(clk_in), .reset(reset), .flush(pipe_flush),
                        .write(xfer_in), .read(xfer_out), .data_in(exe_dout),
                        .full(pipe_full), .data_out(out_data));

endmodule

// File: sim/execute_assertions.sv
module execute_assertions
#(
   parameter exe_pkg::word_t win_lo = 32'h0000_0000,
   parameter exe_pkg::word_t win_hi = 32'h0000_7FFF
)
(
   input logic                                   clk_in,
   input logic                                   reset,
   input logic                                   cpu_halt,
   input logic                                   pipe_flush,
   input logic                                   in_valid,
   input logic                                   in_ready,
   input exe_pkg::dec_to_exe_t                   in_data,
   input exe_pkg::word_t [exe_pkg::num_gprs-1:0] gpr,
   input exe_pkg::fwd_gpr_t                      fwd_mem,
   input exe_pkg::fwd_gpr_t                      fwd_wb,
   input logic                                   out_valid,
   input logic                                   out_ready,
   input exe_pkg::exe_to_mem_t                   out_data,
   input logic                                   rld_pc_flag,
   input exe_pkg::pc_t                           rld_pc_addr
);
   timeunit 1ns;
   timeprecision 1ps;

   int             err_count = 0;                // Read by the testbench at the end
   logic           xfer;
   logic           is_addsub;
   logic           is_br;
   logic           is_jal;
   logic           is_ls;
   logic           taken;
   exe_pkg::word_t a;                            // Expected Rs1 after forwarding
   exe_pkg::word_t b;
   exe_pkg::word_t y;                            // ALU second operand
   exe_pkg::word_t alu_exp;
   exe_pkg::pc_t   tgt;                          // Expected branch target
   exe_pkg::word_t ea;
   logic           ea_mis;
   exe_pkg::word_t alu_q;
   exe_pkg::word_t link_q;
   exe_pkg::word_t ea_q;
   logic           ea_mis_q;
   logic           win_q;

   // MEM over WB over the register file, x0 never forwarded
   function automatic exe_pkg::word_t operand(input exe_pkg::reg_addr_t addr, input logic rd);
      if (rd && addr != 0 && fwd_mem.valid && fwd_mem.rd_wr && fwd_mem.rd_addr == addr)
         return fwd_mem.rd_data;
      if (rd && addr != 0 && fwd_wb.valid && fwd_wb.rd_wr && fwd_wb.rd_addr == addr)
         return fwd_wb.rd_data;
      return gpr[addr];
   endfunction

   // ------------------------------------------------------------
   // Reference values from the instruction set rules
   // ------------------------------------------------------------
   always_comb
   begin
      xfer      = in_valid & in_ready;
      a         = operand(in_data.rs1_addr, in_data.rs1_rd);
      b         = operand(in_data.rs2_addr, in_data.rs2_rd);
      is_addsub = (in_data.ig == exe_pkg::alu_instr) && (in_data.sel_x == exe_pkg::sel_rs)
                  && (in_data.op == 4'd0 || in_data.op == 4'd1);
      y         = (in_data.sel_y == exe_pkg::sel_imm) ? in_data.imm : b;
      alu_exp   = (in_data.op == 4'd0) ? a + y : a - y;
      is_br     = (in_data.ig == exe_pkg::br_instr);
      is_jal    = is_br && (in_data.op[1:0] == 2'd1);
      is_ls     = (in_data.ig == exe_pkg::ld_instr) || (in_data.ig == exe_pkg::st_instr);
      case (in_data.funct3)
         3'b000:  taken = a == b;
         3'b001:  taken = a != b;
         3'b100:  taken = $signed(a) < $signed(b);
         3'b101:  taken = $signed(a) >= $signed(b);
         3'b110:  taken = a < b;
         3'b111:  taken = a >= b;
         default: taken = 1'b0;
      endcase
      if (in_data.op[1:0] == 2'd1)
         tgt = in_data.pc + in_data.imm;         // JAL
      else if (in_data.op[1:0] == 2'd2)
         tgt = (a + in_data.imm) & ~32'd1;       // JALR
      else
         tgt = taken ? in_data.pc + in_data.imm : in_data.pc + 4;
      ea     = a + in_data.imm;
      ea_mis = (in_data.funct3[1:0] == 2'b01) ? ea[0] :
               (in_data.funct3[1:0] == 2'b00) ? 1'b0 : (ea[1:0] != 2'b00);
   end

   // Expected record fields, one cycle behind the transfer
   always_ff @(posedge clk_in)
   begin
      alu_q    <= alu_exp;
      link_q   <= in_data.pc + 4;
      ea_q     <= ea;
      ea_mis_q <= ea_mis;
      win_q    <= (ea >= win_lo) && (ea <= win_hi);
   end

   // ------------------------------------------------------------
   // Checks
   // ------------------------------------------------------------
   gate_ready: assert property (@(posedge clk_in) reset || cpu_halt || pipe_flush |-> !in_ready)
      else
      begin
         err_count++;
         $error("Input ready high during reset, halt or flush");
      end
   reset_empty: assert property (@(posedge clk_in) reset |=> !out_valid)
      else
      begin
         err_count++;
         $error("Pipe register not empty after reset");
      end
   reset_rld: assert property (@(posedge clk_in) reset && !in_valid |-> !rld_pc_flag)
      else
      begin
         err_count++;
         $error("PC reload raised during reset");
      end
   latency: assert property (@(posedge clk_in) disable iff (reset) xfer |=> out_valid)
      else
      begin
         err_count++;
         $error("Accepted instruction did not reach the pipe register");
      end
   alu_res: assert property (@(posedge clk_in) disable iff (reset)
      xfer && is_addsub |=> out_data.rd_data == alu_q)
      else
      begin
         err_count++;
         $error("FAILED t=%0t rd_data got %h exp %h", $time, out_data.rd_data, alu_q);
      end
   reload: assert property (@(posedge clk_in) disable iff (reset)
      in_valid && is_br && !tgt[1] && in_data.predicted_addr != tgt
      |-> rld_pc_flag && rld_pc_addr == tgt)
      else
      begin
         err_count++;
         $error("FAILED t=%0t rld_pc_addr got %h exp %h", $time, rld_pc_addr, tgt);
      end
   mispre_rec: assert property (@(posedge clk_in) disable iff (reset)
      xfer && is_br && !tgt[1] && in_data.predicted_addr != tgt |=> out_data.mispre)
      else
      begin
         err_count++;
         $error("Mispredicted branch record lacks mispre");
      end
   jal_link: assert property (@(posedge clk_in) disable iff (reset)
      xfer && is_jal && !tgt[1] && in_data.predicted_addr == tgt |=> out_data.rd_data == link_q)
      else
      begin
         err_count++;
         $error("FAILED t=%0t rd_data got %h exp %h", $time, out_data.rd_data, link_q);
      end
   x0_wr: assert property (@(posedge clk_in) disable iff (reset)
      out_valid && out_data.rd_addr == 0 |-> !out_data.rd_wr)
      else
      begin
         err_count++;
         $error("Record writes register zero");
      end
   ls_addr: assert property (@(posedge clk_in) disable iff (reset)
      xfer && is_ls |=> out_data.ls_addr == ea_q && out_data.mis == ea_mis_q)
      else
      begin
         err_count++;
         $error("FAILED t=%0t ls_addr/mis got %h/%b exp %h/%b", $time,
                out_data.ls_addr, out_data.mis, ea_q, ea_mis_q);
      end
   st_inv: assert property (@(posedge clk_in) disable iff (reset)
      xfer && in_data.ig == exe_pkg::st_instr |=> out_data.inv_flag == win_q)
      else
      begin
         err_count++;
         $error("FAILED t=%0t inv_flag got %b exp %b", $time, out_data.inv_flag, win_q);
      end
   hold: assert property (@(posedge clk_in) disable iff (reset)
      out_valid && !out_ready |=> $stable(out_data))
      else
      begin
         err_count++;
         $error("Record changed under back-pressure");
      end
   stall: assert property (@(posedge clk_in) disable iff (reset)
      out_valid && !out_ready |-> !in_ready)
      else
      begin
         err_count++;
         $error("Input ready while output stalled");
      end
   flush: assert property (@(posedge clk_in) disable iff (reset) pipe_flush |=> !out_valid)
      else
      begin
         err_count++;
         $error("Pipe register not empty after flush");
      end

endmodule

// File: sim/execute_tb.sv
module execute_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int max_wait = 200;

   logic                                   clk_in;
   logic                                   reset;
   logic                                   cpu_halt;
   logic                                   pipe_flush;
   logic                                   in_valid;
   logic                                   in_ready;
   exe_pkg::dec_to_exe_t                   in_data;
   exe_pkg::word_t [exe_pkg::num_gprs-1:0] gpr;
   exe_pkg::fwd_gpr_t                      fwd_mem;
   exe_pkg::fwd_gpr_t                      fwd_wb;
   logic                                   out_valid;
   logic                                   out_ready;
   exe_pkg::exe_to_mem_t                   out_data;
   logic                                   rld_pc_flag;
   exe_pkg::pc_t                           rld_pc_addr;
   logic                                   hold_low;     // Forces back-pressure
   int                                     timeouts;

   execute_stage dut0 (.*);

   bind execute_stage execute_assertions #(.win_lo(32'h0), .win_hi(32'h7FFF)) u_chk
   (
      .clk_in(clk_in), .reset(reset), .cpu_halt(cpu_halt), .pipe_flush(pipe_flush),
      .in_valid(in_valid), .in_ready(in_ready), .in_data(in_data), .gpr(gpr),
      .fwd_mem(fwd_mem), .fwd_wb(fwd_wb), .out_valid(out_valid), .out_ready(out_ready),
      .out_data(out_data), .rld_pc_flag(rld_pc_flag), .rld_pc_addr(rld_pc_addr)
   );

   initial
   begin
      clk_in = 1'b0;
      forever #10 clk_in = ~clk_in;
   end

   // Memory side accepts about three cycles in four
   initial
   begin
      logic hold_now;
      out_ready = 1'b0;
      forever
      begin
         @(posedge clk_in);
         hold_now = hold_low;
         #2 out_ready = hold_now ? 1'b0 : ($urandom % 4 != 0);
      end
   end

   function automatic exe_pkg::dec_to_exe_t make_instr
   (
      input exe_pkg::instr_group_t ig, input logic [3:0] op, input logic [2:0] funct3,
      input exe_pkg::reg_addr_t rd, input exe_pkg::reg_addr_t rs1, input exe_pkg::reg_addr_t rs2,
      input exe_pkg::word_t imm, input exe_pkg::pc_t pc, input exe_pkg::pc_t pred
   );
      exe_pkg::dec_to_exe_t i;
      i                = '0;
      i.ig             = ig;
      i.op             = op;
      i.funct3         = funct3;
      i.rd_addr        = rd;
      i.rs1_addr       = rs1;
      i.rs2_addr       = rs2;
      i.imm            = imm;
      i.pc             = pc;
      i.predicted_addr = pred;
      i.sel_x          = exe_pkg::sel_rs;
      i.sel_y          = ($urandom % 2) ? exe_pkg::sel_imm : exe_pkg::sel_rs;
      i.rd_wr          = (ig != exe_pkg::st_instr);
      i.rs1_rd         = 1'b1;
      i.rs2_rd         = 1'b1;
      return i;
   endfunction

   // Fresh register file and forwards for each instruction
   task automatic shuffle_sources();
      foreach (gpr[r])
         gpr[r] = (r == 0) ? '0 : $urandom;
      fwd_mem = '{valid: 1'($urandom % 2), rd_wr: 1'b1,
                  rd_addr: exe_pkg::reg_addr_t'($urandom % 8), rd_data: $urandom};
      fwd_wb  = '{valid: 1'($urandom % 2), rd_wr: 1'b1,
                  rd_addr: exe_pkg::reg_addr_t'($urandom % 8), rd_data: $urandom};
   endtask

   // Hold the instruction until the handshake, bounded
   task automatic send(input exe_pkg::dec_to_exe_t instr);
      int   n;
      logic done;
      n        = 0;
      done     = 1'b0;
      in_data  = instr;
      in_valid = 1'b1;
      while (!done && n < max_wait)
      begin
         #8 done = in_ready;                       // Mid-cycle, inputs settled
         @(posedge clk_in);
         #2 n++;
      end
      if (!done)
      begin
         timeouts++;
         $display("Timeout at %0t waiting for in_ready", $time);
      end
      in_valid = 1'b0;
   endtask

   task automatic wait_out_valid();
      int n;
      n = 0;
      while (!out_valid && n < max_wait)
      begin
         @(posedge clk_in);
         #2 n++;
      end
      if (!out_valid)
      begin
         timeouts++;
         $display("Timeout at %0t waiting for out_valid", $time);
      end
   endtask

   initial
   begin
      exe_pkg::word_t        a;
      exe_pkg::pc_t          pc;
      exe_pkg::instr_group_t ig;
      logic [3:0]            op;
      void'($urandom(99570));
      timeouts   = 0;
      reset      = 1'b1;
      cpu_halt   = 1'b0;
      pipe_flush = 1'b0;
      in_valid   = 1'b0;
      in_data    = '0;
      hold_low   = 1'b0;
      shuffle_sources();
      repeat (16) @(posedge clk_in);
      #2 reset = 1'b0;

      // ------------------------------------------------------------
      // Directed: forwarding, x0, JAL, loads and stores
      // ------------------------------------------------------------
      fwd_mem = '{valid: 1'b1, rd_wr: 1'b1, rd_addr: 5'd5, rd_data: 32'h1111_0000};
      fwd_wb  = '{valid: 1'b1, rd_wr: 1'b1, rd_addr: 5'd5, rd_data: 32'h2222_0000};
      send(make_instr(exe_pkg::alu_instr, 4'd0, 3'd0, 5'd3, 5'd5, 5'd6, 32'd7, 32'h100, 0));
      fwd_mem.rd_addr = 5'd0;
      fwd_wb.rd_addr  = 5'd6;
      send(make_instr(exe_pkg::alu_instr, 4'd1, 3'd0, 5'd0, 5'd0, 5'd6, 32'd9, 32'h104, 0));
      send(make_instr(exe_pkg::br_instr, 4'd1, 3'd0, 5'd1, 5'd0, 5'd0, 32'h40, 32'h200, 32'h240));
      send(make_instr(exe_pkg::br_instr, 4'd1, 3'd0, 5'd1, 5'd0, 5'd0, 32'h40, 32'h300, 32'h304));
      gpr[7] = 32'h0000_7FFD;                       // Near the top of the cache window
      send(make_instr(exe_pkg::st_instr, 4'd0, 3'd2, 5'd0, 5'd7, 5'd2, 32'd2, 32'h400, 0));
      send(make_instr(exe_pkg::st_instr, 4'd0, 3'd1, 5'd0, 5'd7, 5'd2, 32'd4, 32'h404, 0));
      send(make_instr(exe_pkg::ld_instr, 4'd0, 3'd5, 5'd4, 5'd7, 5'd0, 32'd1, 32'h408, 0));

      // Back-pressure then flush
      hold_low = 1'b1;
      send(make_instr(exe_pkg::alu_instr, 4'd0, 3'd0, 5'd8, 5'd1, 5'd2, 32'd1, 32'h500, 0));
      wait_out_valid();
      repeat (3) @(posedge clk_in);
      #2 pipe_flush = 1'b1;
      @(posedge clk_in);
      #2 pipe_flush = 1'b0;
      hold_low = 1'b0;

      // Decode waits while the core is halted
      cpu_halt = 1'b1;
      fork
         send(make_instr(exe_pkg::alu_instr, 4'd1, 3'd0, 5'd9, 5'd3, 5'd4, 32'd5, 32'h600, 0));
         begin
            repeat (3) @(posedge clk_in);
            #2 cpu_halt = 1'b0;
         end
      join

      // ------------------------------------------------------------
      // Random mix
      // ------------------------------------------------------------
      repeat (300)
      begin
         shuffle_sources();
         pc = ($urandom % 1024) << 2;
         a  = ($urandom % 2) ? pc + 4 : $urandom & 32'hFFFF_FFFC;
         ig = exe_pkg::instr_group_t'($urandom % 5);
         op = (ig == exe_pkg::br_instr) ? 4'($urandom % 3) : 4'($urandom % 10); // JAL/JALR top
         send(make_instr(ig, op, 3'($urandom % 8),
                         exe_pkg::reg_addr_t'($urandom % 8),
                         exe_pkg::reg_addr_t'($urandom % 8),
                         exe_pkg::reg_addr_t'($urandom % 8),
                         ($urandom % 2) ? $urandom : $urandom % 64, pc, a));
      end
      wait_out_valid();
      repeat (4) @(posedge clk_in);

      $display("Checker errors: %0d, timeouts: %0d", dut0.u_chk.err_count, timeouts);
      if (dut0.u_chk.err_count == 0 && timeouts == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

// File: compile.f
design/exe_pkg.sv
design/operand_forward.sv
design/alu_unit.sv
design/branch_unit.sv
design/ls_unit.sv
design/exe_result_select.sv
design/exe_pipe_reg.sv
design/execute_stage.sv
sim/execute_assertions.sv
sim/execute_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= execute_tb
SEED      ?= 99570
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED)); \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
